// File: logic/fas_cfg.svh
// spectrum analyzer constants
`ifndef FAS_CFG_SVH
`define FAS_CFG_SVH

`define FAS_SAMPLE_W 16
`define FAS_TAPS     32
`define FAS_ACC_W    36
`define FAS_POINTS   16
`define FAS_WIDE_W   48
`define FAS_MAG_W    32
`define FAS_BIN_W    4
`define FAS_Q16_ONE  65536

// low-pass, q16 scaled, tap k pairs with tap 31-k
`define FAS_FIR_C00 (-79)
`define FAS_FIR_C01 (-92)
`define FAS_FIR_C02 (131)
`define FAS_FIR_C03 (190)
`define FAS_FIR_C04 (-288)
`define FAS_FIR_C05 (-413)
`define FAS_FIR_C06 (590)
`define FAS_FIR_C07 (819)
`define FAS_FIR_C08 (-1108)
`define FAS_FIR_C09 (-1488)
`define FAS_FIR_C10 (1992)
`define FAS_FIR_C11 (2694)
`define FAS_FIR_C12 (-3749)
`define FAS_FIR_C13 (-5551)
`define FAS_FIR_C14 (9627)
`define FAS_FIR_C15 (29440)

// W16^n = exp(-j*2*pi*n/16) in q16
`define FAS_W1_RE (60547)
`define FAS_W1_IM (-25079)
`define FAS_W2_RE (46340)
`define FAS_W2_IM (-46340)
`define FAS_W3_RE (25079)
`define FAS_W3_IM (-60547)
`define FAS_W4_RE (0)
`define FAS_W4_IM (-65536)
`define FAS_W5_RE (-25079)
`define FAS_W5_IM (-60547)
`define FAS_W6_RE (-46340)
`define FAS_W6_IM (-46340)
`define FAS_W7_RE (-60547)
`define FAS_W7_IM (-25079)

`endif

// File: logic/fas_pkg.sv
// spectrum analyzer types
`include "fas_cfg.svh"

package fas_pkg;

    // input samples and rounded spectrum parts
    typedef logic signed [`FAS_SAMPLE_W-1:0] sample_t;

    // fir sum before truncation
    typedef logic signed [`FAS_ACC_W-1:0] acc_t;

    // fft internal real or imaginary part, q16
    typedef logic signed [`FAS_WIDE_W-1:0] wide_t;

    typedef logic [`FAS_MAG_W-1:0] mag_t;

    typedef logic [`FAS_BIN_W-1:0] bin_t;

    // fir sample line fill
    typedef enum logic {
        FILLING,
        RUNNING
    } fill_state_t;

endpackage

// File: logic/fir_filter.sv
// symmetric fir low-pass
`timescale 1ns/100ps
`include "fas_cfg.svh"

module fir_filter (
    input  logic             clk,
    input  logic             rst,
    input  logic             data_valid_i,
    input  fas_pkg::sample_t data_i,
    output fas_pkg::sample_t fir_d_o,
    output logic             fir_valid_o
);
    import fas_pkg::*;

    localparam int HALF = `FAS_TAPS / 2;
    localparam int COEF [HALF] = '{
        `FAS_FIR_C00, `FAS_FIR_C01, `FAS_FIR_C02, `FAS_FIR_C03,
        `FAS_FIR_C04, `FAS_FIR_C05, `FAS_FIR_C06, `FAS_FIR_C07,
        `FAS_FIR_C08, `FAS_FIR_C09, `FAS_FIR_C10, `FAS_FIR_C11,
        `FAS_FIR_C12, `FAS_FIR_C13, `FAS_FIR_C14, `FAS_FIR_C15
    };

    // x_line[0] is the newest stored sample
    sample_t     x_line [`FAS_TAPS-1];
    sample_t     taps   [`FAS_TAPS];
    fill_state_t state;
    logic [4:0]  fill_cnt;
    logic        line_full;
    acc_t        acc;

    // taps as they will be once data_i shifts in
    always_comb begin
        taps[0] = data_i;
        for (int j = 1; j < `FAS_TAPS; j++) begin
            taps[j] = x_line[j-1];
        end
    end

    always_comb begin
        acc = '0;
        for (int k = 0; k < HALF; k++) begin
            acc = acc + (acc_t'(taps[k]) + acc_t'(taps[`FAS_TAPS-1-k])) * acc_t'(COEF[k]);
        end
    end

    // 31 samples already held
    assign line_full = (state == RUNNING) || (fill_cnt == 5'd31);

    always_ff @(posedge clk) begin
        if (data_valid_i) begin
            x_line[0] <= data_i;
            for (int j = 1; j < `FAS_TAPS - 1; j++) begin
                x_line[j] <= x_line[j-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= FILLING;
            fill_cnt <= '0;
        end else if (data_valid_i && state == FILLING) begin
            if (fill_cnt == 5'd31) begin
                state <= RUNNING;
            end else begin
                fill_cnt <= fill_cnt + 5'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fir_valid_o <= 1'b0;
        end else begin
            fir_valid_o <= data_valid_i && line_full;
        end
    end

    // keep sign, drop the q16 fraction
    always_ff @(posedge clk) begin
        if (data_valid_i) begin
            fir_d_o <= {acc[`FAS_ACC_W-1], acc[30:16]};
        end
    end

    // a result only once the fill state machine has left FILLING
    a_valid_follows_input: assert property (
        @(posedge clk) disable iff (rst)
        fir_valid_o |-> $past(data_valid_i) && (state == RUNNING)
    );

endmodule

// File: logic/frame_buffer.sv
// filtered sample framer
`timescale 1ns/100ps
`include "fas_cfg.svh"

module frame_buffer (
    input  logic             clk,
    input  logic             rst,
    input  fas_pkg::sample_t fir_d_i,
    input  logic             fir_valid_i,
    output fas_pkg::sample_t frame_o [`FAS_POINTS],
    output logic             frame_valid_o
);
    import fas_pkg::*;

    localparam logic [3:0] LAST_SLOT = 4'(`FAS_POINTS - 1);

    // the last sample goes straight to the frame
    sample_t    slots [`FAS_POINTS-1];
    logic [3:0] slot_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_cnt      <= '0;
            frame_valid_o <= 1'b0;
        end else begin
            frame_valid_o <= fir_valid_i && (slot_cnt == LAST_SLOT);
            if (fir_valid_i) begin
                slot_cnt <= slot_cnt + 4'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fir_valid_i) begin
            if (slot_cnt == LAST_SLOT) begin
                for (int i = 0; i < `FAS_POINTS - 1; i++) begin
                    frame_o[i] <= slots[i];
                end
                frame_o[`FAS_POINTS-1] <= fir_d_i;
            end else begin
                slots[slot_cnt] <= fir_d_i;
            end
        end
    end

    a_frame_strobe_single: assert property (
        @(posedge clk) disable iff (rst) frame_valid_o |=> !frame_valid_o
    );

endmodule

// File: logic/fft16_core.sv
// 16-point radix-4 fft
`timescale 1ns/100ps
`include "fas_cfg.svh"

module fft16_core (
    input  logic             clk,
    input  logic             rst,
    input  fas_pkg::sample_t frame_i [`FAS_POINTS],
    input  logic             frame_valid_i,
    output fas_pkg::sample_t spec_re_o [`FAS_POINTS],
    output fas_pkg::sample_t spec_im_o [`FAS_POINTS],
    output logic             spec_valid_o
);
    import fas_pkg::*;

    localparam int R = 4;

    // W16^e for e = 0..9, e = n1*k1
    localparam int TW_RE [10] = '{
        `FAS_Q16_ONE, `FAS_W1_RE, `FAS_W2_RE, `FAS_W3_RE, `FAS_W4_RE,
        `FAS_W5_RE, `FAS_W6_RE, `FAS_W7_RE, -`FAS_Q16_ONE, -`FAS_W1_RE
    };
    localparam int TW_IM [10] = '{
        0, `FAS_W1_IM, `FAS_W2_IM, `FAS_W3_IM, `FAS_W4_IM,
        `FAS_W5_IM, `FAS_W6_IM, `FAS_W7_IM, 0, -`FAS_W1_IM
    };

    wide_t   p1_re_d [R][R];
    wide_t   p1_im_d [R][R];
    wide_t   p1_re   [R][R];
    wide_t   p1_im   [R][R];
    logic    p1_valid;
    sample_t bin_re_d [`FAS_POINTS];
    sample_t bin_im_d [`FAS_POINTS];

    // 4-point dft, W4 = -j
    function automatic void bfly4(input wide_t a_re [R], input wide_t a_im [R],
                                  output wide_t y_re [R], output wide_t y_im [R]);
        wide_t s0_re;
        wide_t s0_im;
        wide_t s1_re;
        wide_t s1_im;
        wide_t d0_re;
        wide_t d0_im;
        wide_t d1_re;
        wide_t d1_im;
        s0_re = a_re[0] + a_re[2];
        s0_im = a_im[0] + a_im[2];
        d0_re = a_re[0] - a_re[2];
        d0_im = a_im[0] - a_im[2];
        s1_re = a_re[1] + a_re[3];
        s1_im = a_im[1] + a_im[3];
        d1_re = a_re[1] - a_re[3];
        d1_im = a_im[1] - a_im[3];
        y_re[0] = s0_re + s1_re;
        y_im[0] = s0_im + s1_im;
        y_re[1] = d0_re + d1_im;
        y_im[1] = d0_im - d1_re;
        y_re[2] = s0_re - s1_re;
        y_im[2] = s0_im - s1_im;
        y_re[3] = d0_re - d1_im;
        y_im[3] = d0_im + d1_re;
    endfunction

    // sign, bits 30..16, round half away from zero
    function automatic sample_t round16(input wide_t v);
        logic        carry;
        logic [15:0] trunc;
        carry = v[`FAS_WIDE_W-1] ? (v[15] & (|v[14:0])) : v[15];
        trunc = {v[`FAS_WIDE_W-1], v[30:16]};
        return sample_t'(trunc + 16'(carry));
    endfunction

    // pass 1: groups (n, n+4, n+8, n+12), then twiddle
    always_comb begin
        wide_t g_re [R];
        wide_t g_im [R];
        wide_t b_re [R];
        wide_t b_im [R];
        int    e;
        for (int n1 = 0; n1 < R; n1++) begin
            for (int n2 = 0; n2 < R; n2++) begin
                g_re[n2] = wide_t'(frame_i[n1 + R*n2]);
                g_im[n2] = '0;
            end
            bfly4(g_re, g_im, b_re, b_im);
            for (int k1 = 0; k1 < R; k1++) begin
                e = n1 * k1;
                p1_re_d[n1][k1] = b_re[k1] * wide_t'(TW_RE[e]) - b_im[k1] * wide_t'(TW_IM[e]);
                p1_im_d[n1][k1] = b_re[k1] * wide_t'(TW_IM[e]) + b_im[k1] * wide_t'(TW_RE[e]);
            end
        end
    end

    // pass 2: columns, bin k1 + 4*k2
    always_comb begin
        wide_t c_re [R];
        wide_t c_im [R];
        wide_t y_re [R];
        wide_t y_im [R];
        for (int k1 = 0; k1 < R; k1++) begin
            for (int n1 = 0; n1 < R; n1++) begin
                c_re[n1] = p1_re[n1][k1];
                c_im[n1] = p1_im[n1][k1];
            end
            bfly4(c_re, c_im, y_re, y_im);
            for (int k2 = 0; k2 < R; k2++) begin
                bin_re_d[k1 + R*k2] = round16(y_re[k2]);
                bin_im_d[k1 + R*k2] = round16(y_im[k2]);
            end
        end
    end

    always_ff @(posedge clk) begin
        p1_re     <= p1_re_d;
        p1_im     <= p1_im_d;
        spec_re_o <= bin_re_d;
        spec_im_o <= bin_im_d;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            p1_valid     <= 1'b0;
            spec_valid_o <= 1'b0;
        end else begin
            p1_valid     <= frame_valid_i;
            spec_valid_o <= p1_valid;
        end
    end

endmodule

// File: logic/peak_detector.sv
// spectral peak search
`timescale 1ns/100ps
`include "fas_cfg.svh"

module peak_detector (
    input  logic             clk,
    input  logic             rst,
    input  fas_pkg::sample_t spec_re_i [`FAS_POINTS],
    input  fas_pkg::sample_t spec_im_i [`FAS_POINTS],
    input  logic             spec_valid_i,
    output fas_pkg::bin_t    freq_o,
    output logic             done_o
);
    import fas_pkg::*;

    mag_t mag_q   [`FAS_POINTS];
    logic mag_valid;
    mag_t cmp_val [`FAS_POINTS];
    bin_t cmp_idx [`FAS_POINTS];

    // squared magnitudes
    always_ff @(posedge clk) begin
        if (spec_valid_i) begin
            for (int i = 0; i < `FAS_POINTS; i++) begin
                mag_q[i] <= spec_re_i[i] * spec_re_i[i] + spec_im_i[i] * spec_im_i[i];
            end
        end
    end

    // pairwise tree, winner lands in slot 0
    always_comb begin
        for (int i = 0; i < `FAS_POINTS; i++) begin
            cmp_val[i] = mag_q[i];
            cmp_idx[i] = bin_t'(i);
        end
        for (int step = 1; step < `FAS_POINTS; step = step * 2) begin
            for (int i = 0; i < `FAS_POINTS; i = i + 2 * step) begin
                // strict compare keeps the lower bin on a tie
                if (cmp_val[i + step] > cmp_val[i]) begin
                    cmp_val[i] = cmp_val[i + step];
                    cmp_idx[i] = cmp_idx[i + step];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mag_valid <= 1'b0;
            done_o    <= 1'b0;
            freq_o    <= '0;
        end else begin
            mag_valid <= spec_valid_i;
            done_o    <= mag_valid;
            if (mag_valid) begin
                freq_o <= cmp_idx[0];
            end
        end
    end

    a_done_pulse: assert property (
        @(posedge clk) disable iff (rst) done_o |=> !done_o
    );

endmodule

// File: logic/fas_top.sv
// fir and fft spectrum analyzer
`timescale 1ns/100ps
`include "fas_cfg.svh"

module fas_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             data_valid_i,
    input  fas_pkg::sample_t data_i,
    output fas_pkg::sample_t fir_d_o,
    output logic             fir_valid_o,
    output fas_pkg::bin_t    freq_o,
    output logic             done_o
);
    import fas_pkg::*;

    sample_t frame   [`FAS_POINTS];
    logic    frame_valid;
    sample_t spec_re [`FAS_POINTS];
    sample_t spec_im [`FAS_POINTS];
    logic    spec_valid;

    fir_filter u_fir (
        .clk          (clk),
        .rst          (rst),
        .data_valid_i (data_valid_i),
        .data_i       (data_i),
        .fir_d_o      (fir_d_o),
        .fir_valid_o  (fir_valid_o)
    );

    frame_buffer u_frame (
        .clk           (clk),
        .rst           (rst),
        .fir_d_i       (fir_d_o),
        .fir_valid_i   (fir_valid_o),
        .frame_o       (frame),
        .frame_valid_o (frame_valid)
    );

    fft16_core u_fft (
        .clk           (clk),
        .rst           (rst),
        .frame_i       (frame),
        .frame_valid_i (frame_valid),
        .spec_re_o     (spec_re),
        .spec_im_o     (spec_im),
        .spec_valid_o  (spec_valid)
    );

    peak_detector u_peak (
        .clk          (clk),
        .rst          (rst),
        .spec_re_i    (spec_re),
        .spec_im_i    (spec_im),
        .spec_valid_i (spec_valid),
        .freq_o       (freq_o),
        .done_o       (done_o)
    );

endmodule

// File: test/tb_fas_tasks.svh
// testbench tasks and directed tests

task automatic check_value(input string what, input longint expected, input longint actual);
    checks++;
    if (expected !== actual) begin
        errors++;
        $display("[FAIL] %s: %s expected %0d, actual %0d", cur_test, what, expected, actual);
    end
endtask

task automatic report_error(input string msg);
    errors++;
    $display("[ERROR] %s: %s", cur_test, msg);
endtask

task automatic idle(input int n);
    repeat (n) @(negedge clk);
endtask

// clears the line model and scoreboard too
task automatic apply_reset();
    rst = 1'b1;
    data_valid_i = 1'b0;
    data_i = '0;
    repeat (16) @(negedge clk);
    for (int i = 0; i < `FAS_TAPS; i++) begin
        hist[i] = '0;
    end
    hist_cnt = 0;
    frame_fill = 0;
    fir_cnt = 0;
    done_cnt = 0;
    exp_fir_q.delete();
    fir_log.delete();
    frame_end_q.delete();
    peak_q.delete();
    rst = 1'b0;
endtask

task automatic drive_sample(input sample_t s);
    data_valid_i = 1'b1;
    data_i = s;
    for (int j = `FAS_TAPS - 1; j > 0; j--) begin
        hist[j] = hist[j-1];
    end
    hist[0] = s;
    hist_cnt++;
    if (hist_cnt >= `FAS_TAPS) begin
        exp_fir_q.push_back(fir_model());
    end
    @(negedge clk);
    data_valid_i = 1'b0;
endtask

task automatic wait_fir_drained();
    int t;
    t = 0;
    while (exp_fir_q.size() != 0 && t < 100) begin
        @(negedge clk);
        t++;
    end
    if (exp_fir_q.size() != 0) begin
        report_error("timed out waiting for fir_valid_o");
    end
endtask

task automatic wait_frames_done();
    int t;
    t = 0;
    while (frame_end_q.size() != 0 && t < 50) begin
        @(negedge clk);
        t++;
    end
    if (frame_end_q.size() != 0) begin
        report_error("timed out waiting for done_o");
    end
endtask

task automatic test_reset_fill();
    cur_test = "reset_fill";
    apply_reset();
    for (int n = 0; n < `FAS_TAPS - 1; n++) begin
        drive_sample(sample_t'(n * 100));
    end
    idle(3);
    check_value("fir_valid_o pulses after 31 samples", 0, fir_cnt);
    check_value("done_o pulses after 31 samples", 0, done_cnt);
    drive_sample(16'sd3100);
    wait_fir_drained();
    check_value("fir_valid_o pulses after 32 samples", 1, fir_cnt);
endtask

task automatic test_impulse();
    int k;
    cur_test = "impulse";
    apply_reset();
    check_peaks = 1'b0;
    for (int n = 0; n < 40; n++) begin
        drive_sample('0);
    end
    drive_sample(16'sd16384);
    for (int n = 0; n < 40; n++) begin
        drive_sample('0);
    end
    wait_fir_drained();
    wait_frames_done();
    check_value("output count", 50, fir_log.size());
    // impulse sits at tap m for output 9+m
    for (int m = 0; m < `FAS_TAPS; m++) begin
        k = (m < `FAS_TAPS / 2) ? m : `FAS_TAPS - 1 - m;
        check_value("impulse response", COEF[k] >>> 2, fir_log[9 + m]);
    end
endtask

task automatic test_random_fir();
    cur_test = "random_fir";
    apply_reset();
    check_peaks = 1'b0;
    for (int n = 0; n < 200; n++) begin
        drive_sample(sample_t'($urandom));
        idle($urandom_range(3, 0));
    end
    wait_fir_drained();
    wait_frames_done();
    check_value("fir_valid_o pulses", 200 - (`FAS_TAPS - 1), fir_cnt);
endtask

task automatic test_dc();
    cur_test = "dc";
    apply_reset();
    check_peaks = 1'b1;
    repeat (`FAS_TAPS - 1 + 2 * `FAS_POINTS) drive_sample(16'sd1500);
    wait_fir_drained();
    wait_frames_done();
    check_value("done_o pulses", 2, done_cnt);
    check_value("dc bin", 0, freq_o);
    cur_test = "zero";
    apply_reset();
    repeat (`FAS_TAPS - 1 + `FAS_POINTS) drive_sample('0);
    wait_fir_drained();
    wait_frames_done();
    check_value("done_o pulses", 1, done_cnt);
    check_value("zero bin", 0, freq_o);
endtask

task automatic test_tones();
    sample_t s;
    for (int k = 1; k <= 3; k++) begin
        cur_test = $sformatf("tone_bin%0d", k);
        apply_reset();
        check_peaks = 1'b1;
        for (int n = 0; n < `FAS_TAPS - 1 + 2 * `FAS_POINTS; n++) begin
            s = sample_t'($rtoi(2000.0 * $cos(2.0 * PI * k * n / `FAS_POINTS)));
            drive_sample(s);
        end
        wait_fir_drained();
        wait_frames_done();
        check_value("done_o pulses", 2, done_cnt);
        check_value("tone bin", k, freq_o);
    end
endtask

task automatic test_frame_count();
    cur_test = "frame_count";
    apply_reset();
    check_peaks = 1'b0;
    // four whole frames and seven spare samples
    for (int n = 0; n < `FAS_TAPS - 1 + 4 * `FAS_POINTS + 7; n++) begin
        drive_sample(sample_t'($urandom_range(1000, 0)));
    end
    wait_fir_drained();
    wait_frames_done();
    idle(8);
    check_value("done_o pulses", 4, done_cnt);
endtask

// File: test/tb_fas.sv
// spectrum analyzer testbench
`timescale 1ns/100ps
`include "fas_cfg.svh"

module tb_fas;
    import fas_pkg::*;

    localparam real PI = 3.14159265358979;
    localparam int COEF [`FAS_TAPS/2] = '{
        `FAS_FIR_C00, `FAS_FIR_C01, `FAS_FIR_C02, `FAS_FIR_C03,
        `FAS_FIR_C04, `FAS_FIR_C05, `FAS_FIR_C06, `FAS_FIR_C07,
        `FAS_FIR_C08, `FAS_FIR_C09, `FAS_FIR_C10, `FAS_FIR_C11,
        `FAS_FIR_C12, `FAS_FIR_C13, `FAS_FIR_C14, `FAS_FIR_C15
    };

    logic    clk;
    logic    rst;
    logic    data_valid_i;
    sample_t data_i;
    sample_t fir_d_o;
    logic    fir_valid_o;
    bin_t    freq_o;
    logic    done_o;

    // line model, hist[0] is the newest sample
    sample_t hist [`FAS_TAPS];
    int      hist_cnt;
    sample_t exp_fir_q [$];
    sample_t fir_log [$];
    sample_t frame_acc [`FAS_POINTS];
    int      frame_fill;
    int      frame_end_q [$];
    int      peak_q [$];
    int      fir_cnt;
    int      done_cnt;
    int      cycle;
    int      exp_bin;
    logic    check_peaks;
    string   cur_test;
    int      checks;
    int      errors;

    fas_top u_fas_top (
        .clk          (clk),
        .rst          (rst),
        .data_valid_i (data_valid_i),
        .data_i       (data_i),
        .fir_d_o      (fir_d_o),
        .fir_valid_o  (fir_valid_o),
        .freq_o       (freq_o),
        .done_o       (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic sample_t fir_model();
        longint      acc;
        logic [63:0] bits;
        acc = 0;
        for (int k = 0; k < `FAS_TAPS / 2; k++) begin
            acc = acc + (longint'(hist[k]) + longint'(hist[`FAS_TAPS-1-k])) * COEF[k];
        end
        bits = acc;
        // sign, then accumulator bits 30..16
        return {bits[63], bits[30:16]};
    endfunction

    // bins above 8 mirror 1..7 for a real frame and lose the tie
    function automatic int dft_peak();
        real re;
        real im;
        real mag;
        real best;
        int  best_bin;
        best = 0.0;
        best_bin = 0;
        for (int k = 0; k <= `FAS_POINTS / 2; k++) begin
            re = 0.0;
            im = 0.0;
            for (int n = 0; n < `FAS_POINTS; n++) begin
                re = re + frame_acc[n] * $cos(2.0 * PI * k * n / `FAS_POINTS);
                im = im - frame_acc[n] * $sin(2.0 * PI * k * n / `FAS_POINTS);
            end
            mag = re * re + im * im;
            if (k == 0 || mag > best + 1.0e-3) begin
                best = mag;
                best_bin = k;
            end
        end
        return best_bin;
    endfunction

    `include "tb_fas_tasks.svh"

    // scoreboard on the falling edge, outputs are stable there
    always @(negedge clk) begin : monitor
        sample_t exp_v;
        if (!rst && fir_valid_o) begin
            fir_cnt++;
            fir_log.push_back(fir_d_o);
            if (exp_fir_q.size() == 0) begin
                report_error("fir_valid_o pulsed before the line held 32 samples");
            end else begin
                exp_v = exp_fir_q.pop_front();
                check_value("fir_d_o", exp_v, fir_d_o);
                frame_acc[frame_fill] = exp_v;
                frame_fill++;
                if (frame_fill == `FAS_POINTS) begin
                    frame_fill = 0;
                    frame_end_q.push_back(cycle);
                    peak_q.push_back(check_peaks ? dft_peak() : -1);
                end
            end
        end
        if (!rst && done_o) begin
            done_cnt++;
            if (frame_end_q.size() == 0) begin
                report_error("done_o pulsed with no frame outstanding");
            end else begin
                check_value("done_o latency", 5, cycle - frame_end_q.pop_front());
                exp_bin = peak_q.pop_front();
                if (exp_bin >= 0) begin
                    check_value("freq_o", exp_bin, freq_o);
                end
            end
        end
    end

    initial begin
        rst = 1'b1;
        data_valid_i = 1'b0;
        data_i = '0;
        check_peaks = 1'b0;
        void'($urandom(32'hc8923809));
        test_reset_fill();
        test_impulse();
        test_random_fir();
        test_dc();
        test_tones();
        test_frame_count();
        idle(4);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+logic
+incdir+test
logic/fas_pkg.sv
logic/fir_filter.sv
logic/frame_buffer.sv
logic/fft16_core.sv
logic/peak_detector.sv
logic/fas_top.sv
test/tb_fas.sv
